// File: design/dither_pkg.sv
// Widths, vector types and sequencer states shared by the dither engine RTL
// Blocks import this package inside their bodies and use scoped names in ports
package dither_pkg;

    // --------------------------------------------------------------------------
    // Geometry of one block
    // --------------------------------------------------------------------------
    localparam int LANES   = 4;
    localparam int PIX_W   = 8;
    localparam int CODE_W  = 2;
    localparam int ERR_W   = 8;
    // Error terms handed from quantizer to store
    localparam int N_TERMS = 6;

    // Output levels are 0, 85, 170, 255
    localparam int LEVEL_STEP = 85;
    // Rounding offset, half a step
    localparam int LEVEL_HALF = 42;

    // --------------------------------------------------------------------------
    // Vector types, lane 0 always in the low bits
    // --------------------------------------------------------------------------
    // Four unsigned samples
    typedef logic [LANES*PIX_W-1:0] pix_t;
    // Four 2-bit level codes
    typedef logic [LANES*CODE_W-1:0] code_t;
    // One signed error term
    typedef logic signed [ERR_W-1:0] err_t;
    // Terms d0..d5, d0 lowest
    typedef logic [N_TERMS*ERR_W-1:0] derr_t;
    // Four lane errors, used for left and top errors alike
    typedef logic [LANES*ERR_W-1:0] lane_err_t;

    // Block sequencer states
    typedef enum logic [1:0] {
        IDLE,
        READ,
        QUANT
    } seq_state_t;

endpackage

// File: design/block_sequencer.sv
// Accepts block strobes, tracks block column and first row, and schedules
// the line memory read one cycle ahead of the quantize strobe
`timescale 1ns/1ps

module block_sequencer #(
    parameter int COLS  = 8,
    parameter int COL_W = 3
) (
     input  logic               clk
    ,input  logic               rst_n
    ,input  logic               frame_start_i
    ,input  logic               blk_valid_i
    ,input  dither_pkg::pix_t   pix_i
    ,output logic               rd_en_o
    ,output logic [COL_W-1:0]   rd_addr_o
    ,output logic               quant_start_o
    ,output logic               mask_left_o
    ,output logic               mask_top_o
    ,output dither_pkg::pix_t   pix_o
    ,output logic [COL_W-1:0]   col_o
);
    import dither_pkg::*;

    seq_state_t       state_q;
    seq_state_t       state_d;
    logic [COL_W-1:0] col_cnt_q;
    logic [COL_W-1:0] col_cur;
    logic             first_row_q;
    logic             first_cur;
    logic             accept;

    // A strobe while READ is pending breaks the spacing rule and is dropped
    assign accept = blk_valid_i && (state_q != READ);

    // Frame start forces column 0 and first row for a block in the same cycle
    assign col_cur   = frame_start_i ? '0 : col_cnt_q;
    assign first_cur = frame_start_i | first_row_q;

    // --------------------------------------------------------------------------
    // State machine
    // --------------------------------------------------------------------------
    always_comb begin
        case (state_q)
            IDLE:    state_d = accept ? READ : IDLE;
            READ:    state_d = QUANT;
            QUANT:   state_d = accept ? READ : IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= IDLE;
            col_cnt_q   <= '0;
            first_row_q <= 1'b1;
        end else begin
            state_q <= state_d;
            if (accept) begin
                // Last column of a row ends the first row
                if (col_cur == COL_W'(COLS - 1)) begin
                    col_cnt_q   <= '0;
                    first_row_q <= 1'b0;
                end else begin
                    col_cnt_q   <= col_cur + 1'b1;
                    first_row_q <= first_cur;
                end
            end else if (frame_start_i) begin
                col_cnt_q   <= '0;
                first_row_q <= 1'b1;
            end
        end
    end

    // Per-block payload, held until the quantizer samples it
    always_ff @(posedge clk) begin
        if (accept) begin
            pix_o       <= pix_i;
            col_o       <= col_cur;
            mask_left_o <= (col_cur == '0);
            mask_top_o  <= first_cur;
        end
    end

    // Read in READ, quantize one cycle later when the data is back
    assign rd_en_o       = (state_q == READ);
    assign rd_addr_o     = col_o;
    assign quant_start_o = (state_q == QUANT);

    // Left error of a block must be stored before the next one quantizes
    a_strobe_spacing: assert property (
        @(posedge clk) disable iff (!rst_n) blk_valid_i |=> !blk_valid_i
    );

endmodule

// File: design/top_error_line_ram.sv
// Line memory of packed below errors, one entry per block column
// Synchronous write and registered read, data one cycle after rd_en_i
`timescale 1ns/1ps

module top_error_line_ram #(
    parameter int COL_W = 3
) (
     input  logic                  clk
    ,input  logic                  rd_en_i
    ,input  logic [COL_W-1:0]      rd_addr_i
    ,output dither_pkg::lane_err_t rd_data_o
    ,input  logic                  wr_en_i
    ,input  logic [COL_W-1:0]      wr_addr_i
    ,input  dither_pkg::lane_err_t wr_data_i
);
    import dither_pkg::*;

    localparam int DEPTH = 2 ** COL_W;

    lane_err_t mem [DEPTH];

    // Write port, fed by the error store
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // Read port, fed by the sequencer
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

    // Sequencer read and store write for one column never coincide
    a_no_rw_collision: assert property (
        @(posedge clk) !(rd_en_i && wr_en_i && (rd_addr_i == wr_addr_i))
    );

endmodule

// File: design/error_quantizer.sv
// Adds diffused left and top errors to a block, saturates and quantizes to
// four levels, and forms the six error terms for the error store
`timescale 1ns/1ps

module error_quantizer #(
    parameter int COL_W = 3
) (
     input  logic                  clk
    ,input  logic                  rst_n
    ,input  logic                  start_i
    ,input  dither_pkg::pix_t      pix_i
    ,input  logic [COL_W-1:0]      col_i
    ,input  logic                  mask_left_i
    ,input  logic                  mask_top_i
    ,input  dither_pkg::lane_err_t left_err_i
    ,input  dither_pkg::lane_err_t top_err_i
    ,output logic                  q_valid_o
    ,output dither_pkg::code_t     q_o
    ,output logic                  store_start_o
    ,output logic [COL_W-1:0]      store_col_o
    ,output dither_pkg::derr_t     derr_o
);
    import dither_pkg::*;

    // Lowest corrected value for codes 1, 2 and 3
    localparam int TH1 = LEVEL_STEP - LEVEL_HALF;
    localparam int TH2 = 2 * LEVEL_STEP - LEVEL_HALF;
    localparam int TH3 = 3 * LEVEL_STEP - LEVEL_HALF;

    err_t              lane_e [LANES];
    logic signed [8:0] diff   [LANES];
    code_t             codes;
    derr_t             terms;
    err_t              d0, d1, d3, d4;
    logic              issued_q;

    // --------------------------------------------------------------------------
    // Per-lane correction and quantization
    // --------------------------------------------------------------------------
    for (genvar g = 0; g < LANES; g++) begin : g_lane
        err_t              left_l;
        err_t              top_l;
        logic signed [10:0] sum;
        logic [PIX_W-1:0]  sat;
        logic [CODE_W-1:0] code;
        logic [PIX_W-1:0]  level;

        // Masked at column 0 and in the first row
        assign left_l = mask_left_i ? '0 : left_err_i[g*ERR_W +: ERR_W];
        assign top_l  = mask_top_i  ? '0 : top_err_i[g*ERR_W +: ERR_W];

        assign sum = $signed({3'b000, pix_i[g*PIX_W +: PIX_W]}) + left_l + top_l;

        // Clamp to 0..255
        always_comb begin
            if (sum < 0) begin
                sat = '0;
            end else if (sum > 11'sd255) begin
                sat = '1;
            end else begin
                sat = sum[PIX_W-1:0];
            end
        end

        // Round to nearest level
        always_comb begin
            if (sat >= TH3) begin
                code = 2'd3;
            end else if (sat >= TH2) begin
                code = 2'd2;
            end else if (sat >= TH1) begin
                code = 2'd1;
            end else begin
                code = 2'd0;
            end
        end

        assign level     = PIX_W'(code * LEVEL_STEP);
        assign diff[g]   = $signed({1'b0, sat}) - $signed({1'b0, level});
        assign lane_e[g] = diff[g][ERR_W-1:0];

        assign codes[g*CODE_W +: CODE_W] = code;
    end

    // --------------------------------------------------------------------------
    // Six error terms, lanes 0 and 2 split in halves
    // --------------------------------------------------------------------------
    assign d0 = lane_e[0] >>> 1;
    assign d1 = lane_e[0] - d0;
    assign d3 = lane_e[2] >>> 1;
    assign d4 = lane_e[2] - d3;

    assign terms = {lane_e[3], d4, d3, lane_e[1], d1, d0};

    // One pulse per start, to the output and to the store
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issued_q <= 1'b0;
        end else begin
            issued_q <= start_i;
        end
    end

    assign q_valid_o     = issued_q;
    assign store_start_o = issued_q;

    always_ff @(posedge clk) begin
        if (start_i) begin
            q_o         <= codes;
            derr_o      <= terms;
            store_col_o <= col_i;
        end
    end

    // Bounded errors rely on the store split staying within one half step
    for (genvar g = 0; g < LANES; g++) begin : g_chk
        a_err_range: assert property (
            @(posedge clk) disable iff (!rst_n)
            start_i |-> (diff[g] >= -43) && (diff[g] <= 42)
        );
    end

endmodule

// File: design/diffusion_error_store.sv
// Turns the six error terms of a block into right-neighbour and below errors
// Left errors go back to the quantizer, below errors into the line memory
`timescale 1ns/1ps

module diffusion_error_store #(
    parameter int COL_W = 3
) (
     input  logic                  clk
    ,input  logic                  rst_n
    ,input  logic                  start_i
    ,input  logic [COL_W-1:0]      col_i
    ,input  dither_pkg::derr_t     derr_i
    ,output dither_pkg::lane_err_t left_err_o
    ,output logic                  top_wr_en_o
    ,output logic [COL_W-1:0]      top_wr_addr_o
    ,output dither_pkg::lane_err_t top_err_o
);
    import dither_pkg::*;

    err_t                   d [N_TERMS];
    logic signed [ERR_W+1:0] d2_x3;
    logic signed [ERR_W+1:0] d5_x3;
    err_t                   left1, left3;
    err_t                   top1, top3;

    for (genvar g = 0; g < N_TERMS; g++) begin : g_term
        assign d[g] = derr_i[g*ERR_W +: ERR_W];
    end

    // --------------------------------------------------------------------------
    // Three-quarter split of lanes 1 and 3
    // --------------------------------------------------------------------------
    assign d2_x3 = d[2] * 10'sd3;
    assign d5_x3 = d[5] * 10'sd3;

    // Upper bits are the arithmetic shift right by two
    assign left1 = d2_x3[ERR_W+1:2];
    assign left3 = d5_x3[ERR_W+1:2];

    // Remainder goes below, so no error is lost
    assign top1 = d[2] - left1;
    assign top3 = d[5] - left3;

    // Left errors feed the next block and must start at zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            left_err_o  <= '0;
            top_wr_en_o <= 1'b0;
        end else begin
            top_wr_en_o <= start_i;
            if (start_i) begin
                left_err_o <= {left3, d[3], left1, d[0]};
            end
        end
    end

    // Below errors, written at the column of the block
    always_ff @(posedge clk) begin
        if (start_i) begin
            top_err_o     <= {top3, d[4], top1, d[1]};
            top_wr_addr_o <= col_i;
        end
    end

endmodule

// File: design/dither_top.sv
// Top level of the ordered-error-diffusion dither engine
// One block per blk_valid_i strobe, codes on q_o two cycles later
`timescale 1ns/1ps

module dither_top #(
    parameter int COLS  = 8,
    parameter int COL_W = 3
) (
     input  logic               clk
    ,input  logic               rst_n
    ,input  logic               frame_start_i
    ,input  logic               blk_valid_i
    ,input  dither_pkg::pix_t   pix_i
    ,output logic               q_valid_o
    ,output dither_pkg::code_t  q_o
);
    import dither_pkg::*;

    // Sequencer to line memory and quantizer
    logic             rd_en;
    logic [COL_W-1:0] rd_addr;
    logic             quant_start;
    logic             mask_left;
    logic             mask_top;
    pix_t             pix;
    logic [COL_W-1:0] col;

    // Line memory read data, the top errors
    lane_err_t        rd_data;

    // Quantizer to store
    derr_t            derr;
    logic             store_start;
    logic [COL_W-1:0] store_col;

    // Store back to quantizer and line memory
    lane_err_t        left_err;
    logic             wr_en;
    logic [COL_W-1:0] wr_addr;
    lane_err_t        wr_data;

    // --------------------------------------------------------------------------
    // Instances
    // --------------------------------------------------------------------------
    block_sequencer #(.COLS(COLS), .COL_W(COL_W)) u_seq (
        .clk(clk), .rst_n(rst_n), .frame_start_i(frame_start_i),
        .blk_valid_i(blk_valid_i), .pix_i(pix_i),
        .rd_en_o(rd_en), .rd_addr_o(rd_addr), .quant_start_o(quant_start),
        .mask_left_o(mask_left), .mask_top_o(mask_top), .pix_o(pix), .col_o(col)
    );

    top_error_line_ram #(.COL_W(COL_W)) u_ram (
        .clk(clk), .rd_en_i(rd_en), .rd_addr_i(rd_addr), .rd_data_o(rd_data),
        .wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_data_i(wr_data)
    );

    error_quantizer #(.COL_W(COL_W)) u_quant (
        .clk(clk), .rst_n(rst_n), .start_i(quant_start), .pix_i(pix), .col_i(col),
        .mask_left_i(mask_left), .mask_top_i(mask_top),
        .left_err_i(left_err), .top_err_i(rd_data),
        .q_valid_o(q_valid_o), .q_o(q_o), .store_start_o(store_start),
        .store_col_o(store_col), .derr_o(derr)
    );

    diffusion_error_store #(.COL_W(COL_W)) u_store (
        .clk(clk), .rst_n(rst_n), .start_i(store_start), .col_i(store_col),
        .derr_i(derr), .left_err_o(left_err), .top_wr_en_o(wr_en),
        .top_wr_addr_o(wr_addr), .top_err_o(wr_data)
    );

endmodule

// File: verification/dither_tb.sv
// Directed testbench for the dither engine top level
// A reference model predicts the code of every block at strobe time, and a
// monitor compares each q_o pulse against the queue of predictions
`timescale 1ns/1ps

module dither_tb;

    localparam int COLS  = 8;
    localparam int COL_W = 3;

    // Blocks over all tests: 1 + 8 + 8 + 32 + 9 + 1
    localparam int TOTAL_BLOCKS   = 59;
    // At most four cycles per block, plus reset, idle and drains
    localparam int DRAIN_LIMIT    = 10;
    localparam int TIMEOUT_CYCLES = 8 + 20 + TOTAL_BLOCKS * 4 + 6 * DRAIN_LIMIT + 200;

    logic                clk;
    logic                rst_n;
    logic                frame_start_i;
    logic                blk_valid_i;
    dither_pkg::pix_t    pix_i;
    logic                q_valid_o;
    dither_pkg::code_t   q_o;

    // Predicted codes, oldest first
    logic [7:0] exp_q[$];
    logic [7:0] mon_exp;
    string      test_name;
    int         cycle_cnt;
    int         seed;

    // Model state: left errors, line of below errors, position in frame
    int mdl_left [4];
    int mdl_top  [COLS][4];
    int mdl_col;
    bit mdl_first;

    dither_top #(.COLS(COLS), .COL_W(COL_W)) u_dut (
        .clk(clk), .rst_n(rst_n), .frame_start_i(frame_start_i),
        .blk_valid_i(blk_valid_i), .pix_i(pix_i),
        .q_valid_o(q_valid_o), .q_o(q_o)
    );

    always #50 clk = ~clk;

    // ------------------------------------------------------------------------
    // Failure reporting and checks
    // ------------------------------------------------------------------------
    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "simulation stopped on failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
            abort_run("Value mismatch, stopping");
        end
    endtask

    // Run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run("Timeout: simulation ran past its cycle limit");
        end
    end

    // Every q_valid_o pulse must match the oldest prediction
    always @(negedge clk) begin
        if (rst_n && q_valid_o) begin
            if (exp_q.size() == 0) begin
                abort_run("q_valid_o pulsed with no block outstanding");
            end else begin
                mon_exp = exp_q.pop_front();
                check_value(test_name, mon_exp, q_o);
            end
        end
    end

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    function automatic logic [7:0] model_block(input logic [31:0] pix);
        int         p;
        int         s;
        int         code;
        int         e   [4];
        int         d   [6];
        int         lft [4];
        int         top [4];
        logic [7:0] q;
        q = '0;
        for (int l = 0; l < 4; l++) begin
            p = pix[8*l +: 8];
            s = p;
            // Masked at column 0 and in the first row
            if (mdl_col != 0) s = s + mdl_left[l];
            if (!mdl_first) s = s + mdl_top[mdl_col][l];
            if (s < 0) s = 0;
            if (s > 255) s = 255;
            code = (s + 42) / 85;
            e[l] = s - 85 * code;
            q[2*l +: 2] = code[1:0];
        end
        // Six terms, lanes 0 and 2 halved
        d[0] = e[0] >>> 1;
        d[1] = e[0] - d[0];
        d[2] = e[1];
        d[3] = e[2] >>> 1;
        d[4] = e[2] - d[3];
        d[5] = e[3];
        // Three-quarter split to the right on lanes 1 and 3
        lft[0] = d[0];
        lft[1] = (d[2] * 3) >>> 2;
        lft[2] = d[3];
        lft[3] = (d[5] * 3) >>> 2;
        top[0] = d[1];
        top[1] = d[2] - lft[1];
        top[2] = d[4];
        top[3] = d[5] - lft[3];
        for (int l = 0; l < 4; l++) begin
            mdl_left[l]         = lft[l];
            mdl_top[mdl_col][l] = top[l];
        end
        if (mdl_col == COLS - 1) begin
            mdl_col   = 0;
            mdl_first = 0;
        end else begin
            mdl_col = mdl_col + 1;
        end
        return q;
    endfunction

    // ------------------------------------------------------------------------
    // Drivers, all entered and left on a falling edge
    // ------------------------------------------------------------------------
    // One strobe, then gap-1 idle cycles
    task automatic send_block(input logic [31:0] pix, input int gap);
        exp_q.push_back(model_block(pix));
        blk_valid_i = 1'b1;
        pix_i       = pix;
        @(negedge clk);
        blk_valid_i = 1'b0;
        repeat (gap - 1) @(negedge clk);
    endtask

    task automatic frame_restart();
        frame_start_i = 1'b1;
        mdl_col       = 0;
        mdl_first     = 1;
        @(negedge clk);
        frame_start_i = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            n++;
            if (n > DRAIN_LIMIT) begin
                abort_run("Expected codes never arrived on q_o");
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------
    task automatic reset_idle_test();
        test_name = "reset_idle";
        repeat (20) begin
            @(negedge clk);
            check_value(test_name, 0, q_valid_o);
        end
    endtask

    // No incoming errors, so 100 rounds to level 85 in all lanes
    task automatic first_block_test(input string name);
        test_name = name;
        wait_drain();
        send_block(32'h6464_6464, 1);
        @(negedge clk);
        check_value({name, "_early"}, 0, q_valid_o);
        @(negedge clk);
        check_value({name, "_valid"}, 1, q_valid_o);
        check_value(name, 8'h55, q_o);
        wait_drain();
    endtask

    task automatic left_diffusion_test();
        test_name = "left_diffusion";
        frame_restart();
        for (int c = 0; c < COLS; c++) begin
            send_block(32'h7878_7878, 2);
        end
        wait_drain();
    endtask

    // Uneven lanes, so the below split on lanes 1 and 3 shows up
    task automatic top_diffusion_test();
        test_name = "top_diffusion";
        for (int c = 0; c < COLS; c++) begin
            send_block(32'hE6BE_6E28, 2);
        end
        wait_drain();
    endtask

    task automatic random_frame_test();
        logic [31:0] pix;
        int          gap;
        test_name = "random_frame";
        frame_restart();
        for (int b = 0; b < 4 * COLS; b++) begin
            pix = $random(seed);
            gap = 2 + ($unsigned($random(seed)) % 3);
            send_block(pix, gap);
        end
        wait_drain();
    endtask

    // Restart in the second row just after a large lane 1 left error
    task automatic frame_restart_test();
        test_name = "frame_restart";
        frame_restart();
        send_block(32'h2080_C0F0, 3);
        send_block(32'h5A5A_5A5A, 2);
        send_block(32'hFF00_7F33, 4);
        for (int c = 3; c < COLS; c++) begin
            send_block(32'h5A5A_5A5A, 2);
        end
        // Top error from column 0 lifts lane 1 to 127
        send_block(32'h5A5A_795A, 2);
        wait_drain();
        frame_restart();
        first_block_test("frame_restart_first");
    endtask

    // ------------------------------------------------------------------------
    // Sequence
    // ------------------------------------------------------------------------
    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        frame_start_i = 1'b0;
        blk_valid_i   = 1'b0;
        pix_i         = '0;
        cycle_cnt     = 0;
        seed          = 7172;
        test_name     = "reset";
        mdl_col       = 0;
        mdl_first     = 1;
        for (int l = 0; l < 4; l++) begin
            mdl_left[l] = 0;
        end
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        reset_idle_test();
        first_block_test("first_block");
        left_diffusion_test();
        top_diffusion_test();
        random_frame_test();
        frame_restart_test();

        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: build.f
design/dither_pkg.sv
design/block_sequencer.sv
design/top_error_line_ram.sv
design/error_quantizer.sv
design/diffusion_error_store.sv
design/dither_top.sv
verification/dither_tb.sv

// File: Bender.yml
package:
  name: dither

sources:
  # Package first, then leaf modules, then the top level
  - design/dither_pkg.sv
  - design/block_sequencer.sv
  - design/top_error_line_ram.sv
  - design/error_quantizer.sv
  - design/diffusion_error_store.sv
  - design/dither_top.sv

  - target: simulation
    files:
      - verification/dither_tb.sv
